// ==== source/thermo_pkg.sv ====
package thermo_pkg;

  // ROM and function commands of the DS18B20.
  localparam logic [7:0] CMD_SKIP_ROM     = 8'hCC;
  localparam logic [7:0] CMD_CONVERT_T    = 8'h44;
  localparam logic [7:0] CMD_READ_SCRATCH = 8'hBE;

  // Reset and presence detect, in microseconds.
  localparam int unsigned T_RESET_LOW_US       = 480;
  localparam int unsigned T_PRESENCE_SAMPLE_US = 70;  // Counted from the release of the bus.
  localparam int unsigned T_RESET_RELEASE_US   = 480;

  // Time slots, in microseconds.
  localparam int unsigned T_SLOT_US        = 70;
  localparam int unsigned T_WRITE1_LOW_US  = 6;
  localparam int unsigned T_WRITE0_LOW_US  = 60;
  localparam int unsigned T_READ_LOW_US    = 2;
  localparam int unsigned T_READ_SAMPLE_US = 12;

  typedef enum logic [1:0] {
    SLOT_RESET,
    SLOT_WRITE0,
    SLOT_WRITE1,
    SLOT_READ
  } slot_kind_t;

  // Scratchpad bytes 0 and 1, two's complement in steps of 1/16 degree.
  typedef logic [15:0] raw_temp_t;

  typedef struct packed {
    logic       negative;
    logic [3:0] hundreds;
    logic [3:0] tens;
    logic [3:0] ones;
    logic [3:0] tenths;
  } temp_reading_t;

  // Active low, bit order gfedcba.
  localparam logic [0:9][6:0] SEG_GLYPH = {
    7'b1000000,
    7'b1111001,
    7'b0100100,
    7'b0110000,
    7'b0011001,
    7'b0010010,
    7'b0000010,
    7'b1111000,
    7'b0000000,
    7'b0010000
  };

  localparam logic [6:0] SEG_MINUS = 7'b0111111;  // Only segment g lit.

endpackage

// ==== source/onewire_slot_engine.sv ====
module onewire_slot_engine #(
  parameter int CLKS_PER_US = 50
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   slot_req,
  input  thermo_pkg::slot_kind_t slot_kind,
  output logic                   slot_busy,
  output logic                   slot_done,
  output logic                   slot_bit,
  output logic                   bus_low,
  input  logic                   bus_in
);

  localparam int PW = (CLKS_PER_US > 1) ? $clog2(CLKS_PER_US) : 1;

  logic [PW-1:0]          pre_cnt;
  logic                   us_tick;
  logic [9:0]             us_cnt;
  thermo_pkg::slot_kind_t kind_q;
  logic [9:0]             low_us;
  logic [9:0]             sample_us;
  logic [9:0]             last_us;
  logic                   sample_en;

  // The prescaler restarts with every slot, so each slot lasts a whole number of microseconds.
  assign us_tick = slot_busy && (pre_cnt == PW'(CLKS_PER_US - 1));

  always_comb begin
    sample_en = 1'b0;
    sample_us = '0;
    case (kind_q)
      thermo_pkg::SLOT_RESET: begin
        low_us    = 10'(thermo_pkg::T_RESET_LOW_US);
        sample_en = 1'b1;
        sample_us = 10'(thermo_pkg::T_RESET_LOW_US + thermo_pkg::T_PRESENCE_SAMPLE_US);
        last_us   = 10'(thermo_pkg::T_RESET_LOW_US + thermo_pkg::T_RESET_RELEASE_US - 1);
      end
      thermo_pkg::SLOT_WRITE0: begin
        low_us  = 10'(thermo_pkg::T_WRITE0_LOW_US);
        last_us = 10'(thermo_pkg::T_SLOT_US);  // One microsecond of recovery on top.
      end
      thermo_pkg::SLOT_WRITE1: begin
        low_us  = 10'(thermo_pkg::T_WRITE1_LOW_US);
        last_us = 10'(thermo_pkg::T_SLOT_US);
      end
      default: begin
        low_us    = 10'(thermo_pkg::T_READ_LOW_US);
        sample_en = 1'b1;
        sample_us = 10'(thermo_pkg::T_READ_SAMPLE_US);
        last_us   = 10'(thermo_pkg::T_SLOT_US);
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_busy <= 1'b0;
      slot_done <= 1'b0;
      slot_bit  <= 1'b0;
      bus_low   <= 1'b0;
      pre_cnt   <= '0;
      us_cnt    <= '0;
      kind_q    <= thermo_pkg::SLOT_RESET;
    end else begin
      slot_done <= 1'b0;
      if (slot_req) begin
        slot_busy <= 1'b1;
        bus_low   <= 1'b1;  // Every slot kind starts with a low pulse.
        kind_q    <= slot_kind;
        pre_cnt   <= '0;
        us_cnt    <= '0;
      end else if (slot_busy) begin
        pre_cnt <= us_tick ? '0 : pre_cnt + 1'b1;
        if (sample_en && us_cnt == sample_us && pre_cnt == '0) begin
          // A presence pulse pulls the bus low.
          slot_bit <= (kind_q == thermo_pkg::SLOT_RESET) ? !bus_in : bus_in;
        end
        if (us_tick) begin
          us_cnt <= us_cnt + 1'b1;
          if (us_cnt + 10'd1 == low_us) begin
            bus_low <= 1'b0;
          end
          if (us_cnt == last_us) begin
            slot_busy <= 1'b0;
            slot_done <= 1'b1;
            bus_low   <= 1'b0;
          end
        end
      end
    end
  end

  a_no_req_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
    slot_req |-> !slot_busy)
    else $error("Slot request arrived while a slot was running.");

  a_low_inside_slot: assert property (@(posedge clk) disable iff (!rst_n)
    bus_low |-> slot_busy)
    else $error("Bus driven low outside a slot.");

endmodule

// ==== source/ds18b20_sequencer.sv ====
module ds18b20_sequencer #(
  parameter int CONV_POLL_LIMIT = 11000
) (
  input  logic                   clk,
  input  logic                   rst_n,
  output logic                   slot_req,
  output thermo_pkg::slot_kind_t slot_kind,
  input  logic                   slot_busy,
  input  logic                   slot_done,
  input  logic                   slot_bit,
  output thermo_pkg::raw_temp_t  raw_temp,
  output logic                   raw_valid,
  output logic                   sensor_fault
);

  localparam int PCW = $clog2(CONV_POLL_LIMIT + 1);

  typedef enum logic [2:0] {
    PH_RST1,
    PH_SKIP1,
    PH_CONV,
    PH_POLL,
    PH_RST2,
    PH_SKIP2,
    PH_RDCMD,
    PH_READ
  } phase_t;

  phase_t                 phase;
  logic                   waiting;
  logic [7:0]             tx_byte;
  logic [3:0]             bit_cnt;
  logic [PCW-1:0]         poll_cnt;
  thermo_pkg::slot_kind_t next_kind;

  always_comb begin
    case (phase)
      PH_RST1, PH_RST2: next_kind = thermo_pkg::SLOT_RESET;
      PH_POLL, PH_READ: next_kind = thermo_pkg::SLOT_READ;
      default:          next_kind = tx_byte[0] ? thermo_pkg::SLOT_WRITE1 : thermo_pkg::SLOT_WRITE0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase        <= PH_RST1;
      waiting      <= 1'b0;
      slot_req     <= 1'b0;
      slot_kind    <= thermo_pkg::SLOT_RESET;
      bit_cnt      <= '0;
      poll_cnt     <= '0;
      raw_valid    <= 1'b0;
      sensor_fault <= 1'b0;
    end else begin
      slot_req  <= 1'b0;
      raw_valid <= 1'b0;
      if (!waiting) begin
        if (!slot_busy) begin
          slot_req  <= 1'b1;
          slot_kind <= next_kind;
          waiting   <= 1'b1;
        end
      end else if (slot_done) begin
        waiting <= 1'b0;
        case (phase)
          PH_RST1, PH_RST2: begin
            sensor_fault <= !slot_bit;
            bit_cnt      <= '0;
            if (!slot_bit) phase <= PH_RST1;  // No sensor, so the whole sequence starts over.
            else if (phase == PH_RST1) phase <= PH_SKIP1;
            else phase <= PH_SKIP2;
          end
          PH_POLL: begin
            if (slot_bit) begin
              phase <= PH_RST2;
            end else if (poll_cnt == PCW'(CONV_POLL_LIMIT - 1)) begin
              phase <= PH_RST1;
            end else begin
              poll_cnt <= poll_cnt + 1'b1;
            end
          end
          PH_READ: begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 4'd15) begin
              raw_valid <= 1'b1;
              phase     <= PH_RST1;
            end
          end
          default: begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 4'd7) begin
              bit_cnt  <= '0;
              poll_cnt <= '0;
              case (phase)
                PH_SKIP1: phase <= PH_CONV;
                PH_CONV:  phase <= PH_POLL;
                PH_SKIP2: phase <= PH_RDCMD;
                default:  phase <= PH_READ;
              endcase
            end
          end
        endcase
      end
    end
  end

  // Command bytes go out LSB first, the temperature word comes in LSB first.
  always_ff @(posedge clk) begin
    if (waiting && slot_done) begin
      case (phase)
        PH_RST1, PH_RST2: tx_byte <= thermo_pkg::CMD_SKIP_ROM;
        PH_SKIP1: tx_byte <= (bit_cnt == 4'd7) ? thermo_pkg::CMD_CONVERT_T : tx_byte >> 1;
        PH_SKIP2: tx_byte <= (bit_cnt == 4'd7) ? thermo_pkg::CMD_READ_SCRATCH : tx_byte >> 1;
        PH_READ:  raw_temp <= {slot_bit, raw_temp[15:1]};
        default:  tx_byte <= tx_byte >> 1;
      endcase
    end
  end

  a_raw_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    raw_valid |=> !raw_valid)
    else $error("raw_valid held for more than one cycle.");

endmodule

// ==== source/temp_decimal_conv.sv ====
module temp_decimal_conv (
  input  logic                      clk,
  input  logic                      rst_n,
  input  thermo_pkg::raw_temp_t     raw_temp,
  input  logic                      raw_valid,
  output thermo_pkg::temp_reading_t reading,
  output logic                      reading_valid
);

  logic [15:0]               mag;
  logic [11:0]               whole;
  logic [7:0]                frac10;
  thermo_pkg::temp_reading_t next_reading;

  assign mag    = raw_temp[15] ? (~raw_temp + 16'd1) : raw_temp;
  assign whole  = mag[15:4];  // Whole degrees.
  assign frac10 = {4'd0, mag[3:0]} * 8'd10;

  always_comb begin
    next_reading.negative = raw_temp[15];
    next_reading.hundreds = 4'(whole / 12'd100);
    next_reading.tens     = 4'((whole / 12'd10) % 12'd10);
    next_reading.ones     = 4'(whole % 12'd10);
    next_reading.tenths   = frac10[7:4];  // Sixteenths times ten, truncated to tenths.
  end

  always_ff @(posedge clk) begin
    if (raw_valid) reading <= next_reading;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) reading_valid <= 1'b0;
    else reading_valid <= raw_valid;
  end

endmodule

// ==== source/fan_control.sv ====
module fan_control #(
  parameter int FAN_ON_C = 26
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  thermo_pkg::temp_reading_t reading,
  input  logic                      reading_valid,
  output logic                      fan_en
);

  logic [10:0] whole_c;

  assign whole_c = reading.hundreds * 11'd100 + reading.tens * 11'd10 + 11'(reading.ones);

  // The decision holds until the next reading arrives.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fan_en <= 1'b0;
    end else if (reading_valid) begin
      fan_en <= !reading.negative && (whole_c >= 11'(FAN_ON_C));
    end
  end

endmodule

// ==== source/seg_display_scan.sv ====
module seg_display_scan #(
  parameter int SCAN_CLKS = 65536
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  thermo_pkg::temp_reading_t reading,
  input  logic                      reading_valid,
  output logic [7:0]                seg,
  output logic [3:0]                an
);

  localparam int SW = $clog2(SCAN_CLKS + 1);

  logic [SW-1:0] scan_cnt;
  logic [1:0]    digit;
  logic          shown;
  logic [6:0]    glyph;

  function automatic logic [6:0] glyph_of(input logic [3:0] d);
    if (d > 4'd9) glyph_of = 7'h7F;  // Blank for anything that is not a decimal digit.
    else glyph_of = thermo_pkg::SEG_GLYPH[d];
  endfunction

  always_comb begin
    case (digit)
      2'd0:    glyph = glyph_of(reading.tenths);
      2'd1:    glyph = glyph_of(reading.ones);
      2'd2:    glyph = glyph_of(reading.tens);
      default: glyph = reading.negative ? thermo_pkg::SEG_MINUS : glyph_of(reading.hundreds);
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      scan_cnt <= '0;
      digit    <= '0;
      shown    <= 1'b0;
      an       <= 4'b1111;
      seg      <= 8'hFF;
    end else begin
      if (reading_valid) shown <= 1'b1;
      if (scan_cnt == SW'(SCAN_CLKS - 1)) begin
        scan_cnt <= '0;
        digit    <= digit + 1'b1;
      end else begin
        scan_cnt <= scan_cnt + 1'b1;
      end
      if (shown) begin
        an  <= ~(4'b0001 << digit);
        seg <= {digit != 2'd1, glyph};  // Decimal point after the ones digit.
      end
    end
  end

  a_one_anode: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(~an))
    else $error("More than one anode active.");

endmodule

// ==== source/thermo_top.sv ====
module thermo_top #(
  parameter int CLKS_PER_US     = 50,
  parameter int CONV_POLL_LIMIT = 11000,
  parameter int SCAN_CLKS       = 65536,
  parameter int FAN_ON_C        = 26
) (
  input  logic       clk,
  input  logic       rst_n,
  inout  wire        dq,
  output logic [7:0] seg,
  output logic [3:0] an,
  output logic       fan_en,
  output logic       sensor_fault
);

  logic                      slot_req;
  thermo_pkg::slot_kind_t    slot_kind;
  logic                      slot_busy;
  logic                      slot_done;
  logic                      slot_bit;
  logic                      bus_low;
  logic                      bus_in;
  thermo_pkg::raw_temp_t     raw_temp;
  logic                      raw_valid;
  thermo_pkg::temp_reading_t reading;
  logic                      reading_valid;

  // Open drain. The external pull-up supplies the high level.
  assign dq     = bus_low ? 1'b0 : 1'bz;
  assign bus_in = dq;

  onewire_slot_engine #(.CLKS_PER_US(CLKS_PER_US)) i_slot_engine (
    .clk, .rst_n, .slot_req, .slot_kind, .slot_busy, .slot_done, .slot_bit,
    .bus_low, .bus_in
  );

  ds18b20_sequencer #(.CONV_POLL_LIMIT(CONV_POLL_LIMIT)) i_sequencer (
    .clk, .rst_n, .slot_req, .slot_kind, .slot_busy, .slot_done, .slot_bit,
    .raw_temp, .raw_valid, .sensor_fault
  );

  temp_decimal_conv i_conv (
    .clk, .rst_n, .raw_temp, .raw_valid, .reading, .reading_valid
  );

  fan_control #(.FAN_ON_C(FAN_ON_C)) i_fan (
    .clk, .rst_n, .reading, .reading_valid, .fan_en
  );

  seg_display_scan #(.SCAN_CLKS(SCAN_CLKS)) i_display (
    .clk, .rst_n, .reading, .reading_valid, .seg, .an
  );

endmodule

// ==== verif/ds18b20_model.sv ====
module ds18b20_model #(
  parameter int US_TIME    = 40,
  parameter int BUSY_POLLS = 3
) (
  inout  wire                   dq,
  input  logic                  present,
  input  thermo_pkg::raw_temp_t temp_word,
  output logic [7:0]            rx_byte,
  output logic [1:0]            rx_pos,
  output logic [31:0]           rx_count,
  output thermo_pkg::raw_temp_t served_word,
  output logic [31:0]           served_cnt
);

  localparam int SAMPLE_US    = 30;  // Write slots are sampled this long after the falling edge.
  localparam int HOLD_ZERO_US = 25;
  localparam int RESET_MIN_US = 400;

  typedef enum logic [1:0] {M_IDLE, M_CMD, M_POLL, M_READ} mode_t;

  mode_t                 mode;
  logic                  drive_low;
  logic                  bit_out;
  logic [7:0]            shift;
  int                    nbits;
  int                    nbytes;
  int                    polls_left;
  int                    rd_idx;
  int                    low_us;
  thermo_pkg::raw_temp_t word_q;

  assign dq = drive_low ? 1'b0 : 1'bz;

  initial begin
    mode        = M_IDLE;
    drive_low   = 1'b0;
    shift       = '0;
    nbits       = 0;
    nbytes      = 0;
    polls_left  = 0;
    rd_idx      = 0;
    word_q      = '0;
    rx_byte     = '0;
    rx_pos      = '0;
    rx_count    = '0;
    served_word = '0;
    served_cnt  = '0;
  end

  task automatic take_bit(input logic b);
    if (mode == M_CMD) begin
      shift = {b, shift[7:1]};  // LSB arrives first.
      nbits++;
      if (nbits == 8) begin
        nbits   = 0;
        rx_byte = shift;
        rx_pos  = (nbytes > 2) ? 2'd2 : 2'(nbytes);
        nbytes++;
        rx_count++;
        if (shift == thermo_pkg::CMD_CONVERT_T) begin
          mode       = M_POLL;
          polls_left = BUSY_POLLS;
        end else if (shift == thermo_pkg::CMD_READ_SCRATCH) begin
          mode   = M_READ;
          rd_idx = 0;
          word_q = temp_word;
        end
      end
    end
  endtask

  task automatic answer_reset();
    mode   = M_IDLE;
    nbits  = 0;
    nbytes = 0;
    if (present) begin
      #(30 * US_TIME);
      drive_low = 1'b1;  // Presence pulse.
      #(120 * US_TIME);
      drive_low = 1'b0;
      mode      = M_CMD;
    end
  endtask

  // Every falling edge from the master opens a slot or a reset.
  always @(negedge dq) begin
    if (!drive_low) begin
      bit_out = 1'b1;
      if (mode == M_POLL) begin
        bit_out = (polls_left == 0);
        if (polls_left > 0) polls_left--;
      end else if (mode == M_READ) begin
        bit_out = word_q[rd_idx];
        rd_idx++;
        if (rd_idx == 16) begin
          mode        = M_IDLE;
          served_word = word_q;
          served_cnt++;
        end
      end
      if (!bit_out) drive_low = 1'b1;  // A zero is held past the master's sample point.
      #(HOLD_ZERO_US * US_TIME);
      drive_low = 1'b0;
      #((SAMPLE_US - HOLD_ZERO_US) * US_TIME);
      if (dq === 1'b1) begin
        take_bit(1'b1);
      end else begin
        low_us = SAMPLE_US;
        while (dq !== 1'b1 && low_us < 1000) begin
          #(US_TIME);
          low_us++;
        end
        if (low_us >= RESET_MIN_US) answer_reset();
        else take_bit(1'b0);
      end
    end
  end

endmodule

// ==== verif/thermo_tb.sv ====
module thermo_tb;

  localparam int CLK_PERIOD      = 20;
  localparam int CLKS_PER_US     = 2;
  localparam int CONV_POLL_LIMIT = 11000;
  localparam int SCAN_CLKS       = 16;
  localparam int FAN_ON_C        = 26;
  localparam int WAIT_SERVED     = 0;
  localparam int WAIT_CHECKED    = 1;
  localparam int WAIT_FAULT      = 2;

  typedef struct packed {
    logic            negative;
    logic [3:0]      hundreds;
    logic [3:0]      tens;
    logic [3:0]      ones;
    logic [3:0]      tenths;
    logic            fan;
    logic [3:0][7:0] seg;  // Expected segments per anode, index 0 is tenths.
  } expect_t;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  present;
  thermo_pkg::raw_temp_t temp_word;
  wire                   dq;
  logic [7:0]            seg;
  logic [3:0]            an;
  logic                  fan_en;
  logic                  sensor_fault;
  logic [7:0]            rx_byte;
  logic [1:0]            rx_pos;
  logic [31:0]           rx_count;
  thermo_pkg::raw_temp_t served_word;
  logic [31:0]           served_cnt;
  int                    checked_cnt = 0;
  int                    checks = 0;
  int                    mismatches = 0;
  int                    failures = 0;
  logic                  want_read = 1'b0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  pullup (dq);

  thermo_top #(
    .CLKS_PER_US(CLKS_PER_US), .CONV_POLL_LIMIT(CONV_POLL_LIMIT),
    .SCAN_CLKS(SCAN_CLKS), .FAN_ON_C(FAN_ON_C)
  ) i_dut (
    .clk, .rst_n, .dq, .seg, .an, .fan_en, .sensor_fault
  );

  ds18b20_model #(.US_TIME(CLKS_PER_US * CLK_PERIOD)) i_sensor (
    .dq, .present, .temp_word, .rx_byte, .rx_pos, .rx_count, .served_word, .served_cnt
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic expect_t expected_of(input thermo_pkg::raw_temp_t w);
    expect_t e;
    int      mag;
    int      whole;
    mag        = w[15] ? 65536 - int'(w) : int'(w);
    whole      = mag / 16;
    e.negative = w[15];
    e.hundreds = 4'(whole / 100);
    e.tens     = 4'((whole / 10) % 10);
    e.ones     = 4'(whole % 10);
    e.tenths   = 4'(((mag % 16) * 10) / 16);  // Truncated, not rounded.
    e.fan      = !w[15] && whole >= FAN_ON_C;
    e.seg[0]   = {1'b1, thermo_pkg::SEG_GLYPH[e.tenths]};
    e.seg[1]   = {1'b0, thermo_pkg::SEG_GLYPH[e.ones]};
    e.seg[2]   = {1'b1, thermo_pkg::SEG_GLYPH[e.tens]};
    e.seg[3]   = {1'b1, e.negative ? thermo_pkg::SEG_MINUS : thermo_pkg::SEG_GLYPH[e.hundreds]};
    return e;
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_failure(input string msg);
    failures++;
    $display("At %0t: %s", $time, msg);
  endtask

  task automatic print_summary();
    $display("Checks: %0d, mismatches: %0d, other failures: %0d", checks, mismatches, failures);
  endtask

  task automatic abort_run(input string msg);
    report_failure(msg);
    print_summary();
    $display("Errors found");
    $finish;
  endtask

  function automatic bit condition_met(input int sel, input int target);
    case (sel)
      WAIT_SERVED:  return served_cnt >= target;
      WAIT_CHECKED: return checked_cnt >= target;
      default:      return sensor_fault === 1'(target);
    endcase
  endfunction

  task automatic wait_until(input int sel, input int target, input int max_clks, input string what);
    int n;
    n = 0;
    while (!condition_met(sel, target) && n < max_clks) begin
      @(negedge clk);
      n++;
    end
    if (!condition_met(sel, target)) abort_run({"Timeout waiting for ", what, "."});
  endtask

  // Visits all four anodes and compares the first sample of each.
  task automatic check_display(input expect_t e);
    logic [3:0] seen;
    int         k;
    seen = '0;
    repeat (4 * SCAN_CLKS) begin
      @(negedge clk);
      case (an)
        4'b1110: k = 0;
        4'b1101: k = 1;
        4'b1011: k = 2;
        4'b0111: k = 3;
        default: k = -1;
      endcase
      if (k >= 0 && !seen[k]) begin
        seen[k] = 1'b1;
        check_value(seg, e.seg[k], $sformatf("seg on an[%0d]", k));
      end
    end
    check_value(seen, 4'hF, "anodes visited in four scan periods");
  endtask

  always @(rx_count) begin : check_commands
    if (rx_count != 0) begin
      if (rx_pos == 2'd0) begin
        check_value(rx_byte, thermo_pkg::CMD_SKIP_ROM, "first command byte after reset");
      end else if (rx_pos == 2'd1) begin
        check_value(rx_byte, want_read ? thermo_pkg::CMD_READ_SCRATCH : thermo_pkg::CMD_CONVERT_T,
                    "second command byte after reset");
        want_read = !want_read;
      end else begin
        report_failure("More than two command bytes followed one reset.");
      end
    end
  end

  always @(negedge clk) begin : compare_readings
    thermo_pkg::raw_temp_t w;
    expect_t               e;
    if (rst_n && i_dut.raw_valid) begin
      w = served_word;
      e = expected_of(w);
      check_value(i_dut.raw_temp, w, "captured temperature word");
      repeat (2) @(negedge clk);
      check_value(fan_en, e.fan, $sformatf("fan_en for word %h", w));
      check_value(sensor_fault, 1'b0, "sensor_fault with a reading");
      repeat (4 * SCAN_CLKS) @(negedge clk);
      check_display(e);
      checked_cnt++;
    end
  end

  task automatic run_fault_window(input expect_t last);
    present = 1'b0;
    wait_until(WAIT_FAULT, 1, 6000, "sensor_fault to rise");
    check_display(last);
    check_value(fan_en, last.fan, "fan_en held during sensor fault");
    present = 1'b1;
    wait_until(WAIT_FAULT, 0, 6000, "sensor_fault to fall");
  endtask

  initial begin : stimulus
    thermo_pkg::raw_temp_t words[$];
    logic [31:0]           rng;
    int                    i;
    rst_n     = 1'b0;
    present   = 1'b1;
    rng       = 32'h72b96c38;
    // 25.0, 25.9375, 26.0, -10.125, -0.5, 125.0, -55.0, 0.0, 85.0625, 0.5
    words = '{16'h0190, 16'h019F, 16'h01A0, 16'hFF5E, 16'hFFF8,
              16'h07D0, 16'hFC90, 16'h0000, 16'h0551, 16'h0008};
    repeat (5) begin
      rng = xorshift32(rng);
      words.push_back(16'(int'(rng % 32'd2881) - 880));  // Sensor range of -55 to +125 degrees.
    end
    temp_word = words[0];
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    check_value(an, 4'hF, "an after reset");
    check_value(fan_en, 1'b0, "fan_en after reset");
    check_value(sensor_fault, 1'b0, "sensor_fault after reset");
    for (i = 0; i < words.size(); i++) begin
      wait_until(WAIT_SERVED, i + 1, 30000, "the sensor to serve a word");
      if (i == 0) begin
        check_value(an, 4'hF, "an before the first reading");
        check_value(fan_en, 1'b0, "fan_en before the first reading");
      end
      if (i + 1 < words.size()) temp_word = words[i + 1];
      wait_until(WAIT_CHECKED, i + 1, 1000, "the reading to be checked");
      if (i == 2) run_fault_window(expected_of(words[i]));
    end
    print_summary();
    if (mismatches == 0 && failures == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== list.f ====
source/thermo_pkg.sv
source/onewire_slot_engine.sv
source/ds18b20_sequencer.sv
source/temp_decimal_conv.sv
source/fan_control.sv
source/seg_display_scan.sv
source/thermo_top.sv
verif/ds18b20_model.sv
verif/thermo_tb.sv

// ==== Bender.yml ====
package:
  name: thermo

sources:
  - source/thermo_pkg.sv
  - source/onewire_slot_engine.sv
  - source/ds18b20_sequencer.sv
  - source/temp_decimal_conv.sv
  - source/fan_control.sv
  - source/seg_display_scan.sv
  - source/thermo_top.sv
  - target: test
    files:
      - verif/ds18b20_model.sv
      - verif/thermo_tb.sv
